//--- alu_operand_gen.sv
////////////////////////////////////////////////////////////
// ALU operand preparation. Decode-side operation fields and
// the constant adder are registered on advance, then joined
// with the issue packet and register data at issue.
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "rv_issue_macros.svh"

module alu_operand_gen (
    input  logic                          clk,
    input  rv_issue_pkg::decode_t         decode_i,
    input  rv_issue_pkg::decoded_t        decoded_i,
    input  logic                          advance_i,
    input  rv_issue_pkg::issue_packet_t   issue_pkt_i,
    input  rv_issue_pkg::rf_read_t        rf_i,
    output rv_issue_pkg::alu_inputs_t     alu_o,
    output logic [`RV_XLEN-1:0]           pc_p4_o
);

    rv_issue_pkg::alu_op_t       alu_op;
    rv_issue_pkg::alu_op_t       alu_op_r;
    rv_issue_pkg::alu_logic_op_t logic_op;
    rv_issue_pkg::alu_logic_op_t logic_op_r;
    logic                        sub_instruction;
    logic                        subtract_r;
    logic                        imm_type_r;
    logic [`RV_XLEN-1:0]         constant_r;
    logic [`RV_XLEN-1:0]         rs2_sel;

    always_comb begin
        if (decoded_i.opcode inside {rv_issue_pkg::LUI, rv_issue_pkg::AUIPC,
                                     rv_issue_pkg::JAL, rv_issue_pkg::JALR}) begin
            alu_op = rv_issue_pkg::ALU_CONSTANT;
        end else begin
            case (decoded_i.fn3)
                3'b010, 3'b011: alu_op = rv_issue_pkg::ALU_SLT;
                3'b001, 3'b101: alu_op = rv_issue_pkg::ALU_SHIFT;
                default:        alu_op = rv_issue_pkg::ALU_ADD_SUB;
            endcase
        end
    end

    always_comb begin
        case (decoded_i.fn3)
            3'b100:  logic_op = rv_issue_pkg::LOGIC_XOR;
            3'b110:  logic_op = rv_issue_pkg::LOGIC_OR;
            3'b111:  logic_op = rv_issue_pkg::LOGIC_AND;
            default: logic_op = rv_issue_pkg::LOGIC_ADD;
        endcase
    end

    // SUB only exists in the register form
    assign sub_instruction = (decoded_i.fn3 == 3'b000) && decode_i.instruction[30]
                           && (decoded_i.opcode == rv_issue_pkg::ARITH);

    // Constant adder covers LUI, AUIPC and the pc+4 link value
    always_ff @(posedge clk) begin
        if (advance_i) begin
            constant_r <= ((decoded_i.opcode == rv_issue_pkg::LUI) ? '0 : decode_i.pc)
                + ((decoded_i.opcode inside {rv_issue_pkg::LUI, rv_issue_pkg::AUIPC}) ?
                   {decode_i.instruction[31:12], 12'b0} : `RV_XLEN'd4);
            imm_type_r <= (decoded_i.opcode == rv_issue_pkg::ARITH_IMM);
            alu_op_r   <= alu_op;
            logic_op_r <= logic_op;
            subtract_r <= (decoded_i.fn3 inside {3'b010, 3'b011}) || sub_instruction;
        end
    end

    assign rs2_sel = imm_type_r ? `RV_XLEN'(signed'(issue_pkt_i.instruction[31:20]))
                                : rf_i.rs2_data;

    // Top bit carries the sign for compares and is cleared for SLTU
    assign alu_o.in1 = {rf_i.rs1_data[`RV_XLEN-1] & ~issue_pkt_i.decoded.fn3[0], rf_i.rs1_data};
    assign alu_o.in2 = {rs2_sel[`RV_XLEN-1] & ~issue_pkt_i.decoded.fn3[0], rs2_sel};

    assign alu_o.constant_adder = constant_r;
    assign alu_o.shift_amount   = imm_type_r ? issue_pkt_i.decoded.rs2 : rf_i.rs2_data[4:0];
    assign alu_o.lshift         = ~issue_pkt_i.decoded.fn3[2];
    assign alu_o.arith          = rf_i.rs1_data[`RV_XLEN-1] & issue_pkt_i.instruction[30];
    assign alu_o.subtract       = subtract_r;
    assign alu_o.alu_op         = alu_op_r;
    assign alu_o.logic_op       = logic_op_r;

    assign pc_p4_o = constant_r;

endmodule

//--- branch_operand_gen.sv
////////////////////////////////////////////////////////////
// Branch and jump operand preparation. The target offset,
// the jump kind and the compare signedness are registered
// on advance; compare operands are extended at issue.
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "rv_issue_macros.svh"

module branch_operand_gen (
    input  logic                          clk,
    input  rv_issue_pkg::decode_t         decode_i,
    input  rv_issue_pkg::decoded_t        decoded_i,
    input  logic                          advance_i,
    input  rv_issue_pkg::issue_packet_t   issue_pkt_i,
    input  rv_issue_pkg::rf_read_t        rf_i,
    input  logic [`RV_XLEN-1:0]           pc_p4_i,
    output rv_issue_pkg::branch_inputs_t  br_o
);

    logic [19:0] jal_imm;
    logic [11:0] br_imm;
    logic [20:0] pc_offset;
    logic [20:0] pc_offset_r;
    logic        jal_r;
    logic        jalr_r;
    logic        use_signed_r;

    assign jal_imm = {decode_i.instruction[31], decode_i.instruction[19:12],
                      decode_i.instruction[20], decode_i.instruction[30:21]};
    assign br_imm  = {decode_i.instruction[31], decode_i.instruction[7],
                      decode_i.instruction[30:25], decode_i.instruction[11:8]};

    always_comb begin
        case (decoded_i.opcode)
            rv_issue_pkg::JAL:  pc_offset = 21'(signed'({jal_imm, 1'b0}));
            rv_issue_pkg::JALR: pc_offset = 21'(signed'(decode_i.instruction[31:20]));
            default:            pc_offset = 21'(signed'({br_imm, 1'b0}));
        endcase
    end

    // BLTU and BGEU compare unsigned
    always_ff @(posedge clk) begin
        if (advance_i) begin
            pc_offset_r  <= pc_offset;
            jal_r        <= (decoded_i.opcode == rv_issue_pkg::JAL);
            jalr_r       <= (decoded_i.opcode == rv_issue_pkg::JALR);
            use_signed_r <= !(decoded_i.fn3 inside {3'b110, 3'b111});
        end
    end

    assign br_o.pc_offset = pc_offset_r;
    assign br_o.jal       = jal_r;
    assign br_o.jalr      = jalr_r;
    assign br_o.fn3       = issue_pkt_i.decoded.fn3;
    assign br_o.rs1       = {rf_i.rs1_data[`RV_XLEN-1] & use_signed_r, rf_i.rs1_data};
    assign br_o.rs2       = {rf_i.rs2_data[`RV_XLEN-1] & use_signed_r, rf_i.rs2_data};
    assign br_o.issue_pc  = issue_pkt_i.pc;
    assign br_o.pc_p4     = pc_p4_i;

endmodule

//--- decode_issue.f
+incdir+.
rv_issue_pkg.sv
instr_decoder.sv
issue_control.sv
alu_operand_gen.sv
ls_operand_gen.sv
branch_operand_gen.sv
decode_issue_top.sv
tb_decode_issue.sv

//--- decode_issue_input.txt
# name instruction pc rs1_data rs2_data stall(none|inuse|notready|flush) unit_onehot exp_a exp_b
# exp_a/exp_b: ALU constant_adder/in2, LS offset/{load,store}, BR pc_offset/rs1 sign, MUL op/rs1
addi_pos 00510093 00001000 11111111 22222222 none 1 00001004 00000005
addi_neg fff20193 00001004 11111111 22222222 none 1 00001008 ffffffff
slti_min 80032293 00002000 00000010 00000020 none 1 00002004 fffff800
sltiu_max 7ff43393 00002008 00000010 00000020 none 1 0000200c 000007ff
srai_imm 40315093 0000b000 80000000 00000000 none 1 0000b004 00000403
add_reg 003100b3 00003000 12345678 deadbeef none 1 00003004 deadbeef
sub_reg 40628233 00003004 00000001 80000000 none 1 00003008 80000000
sltu_reg 003130b3 00003008 ffffffff 90000000 none 1 0000300c 90000000
lui_imm 12345537 00003008 aaaaaaaa 55555555 none 1 12345000 55555555
auipc_pos 00010597 00004000 00000000 0000abcd none 1 00014000 0000abcd
auipc_wrap fffff597 00004000 00000000 0000abcd none 1 00003000 0000abcd
mul_reg 023100b3 00005000 11111111 22222222 none 8 00000000 11111111
mulh_reg 023110b3 00005004 87654321 22222222 none 8 00000001 87654321
mulhu_reg 023130b3 00005008 80000000 ffffffff none 8 00000003 80000000
div_reg 023140b3 0000500c 0000ffff 00000003 none 8 00000000 0000ffff
lw_pos 00c32283 00006000 00001000 00000000 none 4 0000000c 00000002
lb_neg ffc10083 00006004 00001000 00000000 none 4 00000ffc 00000002
sw_pos 00742423 00006008 00002000 cafef00d none 4 00000008 00000001
sb_neg fe950fa3 0000600c 00002000 000000ff none 4 00000fff 00000001
beq_fwd 00208863 00007000 80000001 80000001 none 2 00000010 00000001
bltu_back fe20ece3 00007004 80000000 00000001 none 2 001ffff8 00000000
bge_far 0041d0e3 00007008 ffffffff 00000000 none 2 00000800 00000001
bgeu_near 0041f263 0000700c f0000000 00000001 none 2 00000004 00000000
jal_fwd 001000ef 00008000 80000000 00000000 none 3 00000800 00000001
jal_back ffdff06f 00008004 80000000 00000000 none 3 001ffffc 00000000
jalr_pos 008280e7 00008008 7fffffff 00000000 none 3 00000008 00000000
jalr_neg ff0280e7 0000800c 80000000 00000000 none 3 001ffff0 00000001
add_inuse 003100b3 00009000 00000005 00000007 inuse 1 00009004 00000007
beq_inuse 00208863 00009004 ffffffff 00000000 inuse 2 00000010 00000001
lw_notready 00c32283 00009008 00000100 00000000 notready 4 0000000c 00000002
mul_notready 023100b3 0000900c 13579bdf 2468ace0 notready 8 00000000 13579bdf
addi_flush 00510093 0000a000 00000001 00000002 flush 0 00000000 00000000
sw_after_flush 00742423 0000a004 00003000 01234567 none 4 00000008 00000001
ecall_flush 00000073 0000a008 00000000 00000000 flush 0 00000000 00000000
addi_after_flush 00510093 0000a00c 00000001 00000002 none 1 0000a010 00000005

//--- decode_issue_top.sv
////////////////////////////////////////////////////////////
// Decode and issue stage top level. Connects the decoder,
// the issue control and the ALU, load/store and branch
// operand generators. Register file read data comes back
// combinationally from the exported source addresses.
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "rv_issue_macros.svh"

module decode_issue_top (
    input  logic                          clk,
    input  logic                          rst,
    input  rv_issue_pkg::decode_t         decode_i,
    output logic                          decode_ready_o,
    input  rv_issue_pkg::rf_read_t        rf_i,
    output logic [`RV_REG_AW-1:0]         rs1_addr_o,
    output logic [`RV_REG_AW-1:0]         rs2_addr_o,
    input  logic [`RV_NUM_UNITS-1:0]      unit_ready_i,
    input  logic                          hold_i,
    input  logic                          flush_i,
    output logic [`RV_NUM_UNITS-1:0]      issue_o,
    output rv_issue_pkg::alu_inputs_t     alu_o,
    output rv_issue_pkg::ls_inputs_t      ls_o,
    output rv_issue_pkg::branch_inputs_t  br_o,
    output rv_issue_pkg::mul_inputs_t     mul_o
);

    rv_issue_pkg::decoded_t      decoded;
    rv_issue_pkg::issue_packet_t issue_pkt;
    logic                        advance;
    logic [`RV_XLEN-1:0]         pc_p4;

    assign rs1_addr_o = issue_pkt.decoded.rs1;
    assign rs2_addr_o = issue_pkt.decoded.rs2;

    instr_decoder u_decoder (
        .instruction_i (decode_i.instruction),
        .decoded_o     (decoded)
    );

    issue_control u_control (
        .clk            (clk),
        .rst            (rst),
        .decode_i       (decode_i),
        .decoded_i      (decoded),
        .rf_i           (rf_i),
        .unit_ready_i   (unit_ready_i),
        .hold_i         (hold_i),
        .flush_i        (flush_i),
        .advance_o      (advance),
        .decode_ready_o (decode_ready_o),
        .issue_pkt_o    (issue_pkt),
        .issue_o        (issue_o),
        .mul_o          (mul_o)
    );

    alu_operand_gen u_alu_gen (
        .clk         (clk),
        .decode_i    (decode_i),
        .decoded_i   (decoded),
        .advance_i   (advance),
        .issue_pkt_i (issue_pkt),
        .rf_i        (rf_i),
        .alu_o       (alu_o),
        .pc_p4_o     (pc_p4)
    );

    ls_operand_gen u_ls_gen (
        .clk         (clk),
        .decode_i    (decode_i),
        .decoded_i   (decoded),
        .advance_i   (advance),
        .issue_pkt_i (issue_pkt),
        .rf_i        (rf_i),
        .ls_o        (ls_o)
    );

    branch_operand_gen u_br_gen (
        .clk         (clk),
        .decode_i    (decode_i),
        .decoded_i   (decoded),
        .advance_i   (advance),
        .issue_pkt_i (issue_pkt),
        .rf_i        (rf_i),
        .pc_p4_i     (pc_p4),
        .br_o        (br_o)
    );

endmodule

//--- instr_decoder.sv
////////////////////////////////////////////////////////////
// Combinational decode of one fetched instruction into its
// register usage, the execution unit it needs and the
// common field aliases kept in the issue register.
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "rv_issue_macros.svh"

module instr_decoder (
    input  logic [31:0]             instruction_i,
    output rv_issue_pkg::decoded_t  decoded_o
);

    rv_issue_pkg::opcode_t opcode;
    logic                  mul_op;

    assign opcode = rv_issue_pkg::opcode_t'(instruction_i[6:2]);

    // M extension register ops carry funct7 bit 0
    assign mul_op = (opcode == rv_issue_pkg::ARITH) && instruction_i[25];

    always_comb begin
        decoded_o = '0;

        decoded_o.opcode = opcode;
        decoded_o.fn3    = instruction_i[14:12];
        decoded_o.rs1    = instruction_i[19:15];
        decoded_o.rs2    = instruction_i[24:20];
        decoded_o.rd     = instruction_i[11:7];

        // Register usage
        decoded_o.uses_rs1 = !(opcode inside {rv_issue_pkg::LUI, rv_issue_pkg::AUIPC,
                                              rv_issue_pkg::JAL});
        decoded_o.uses_rs2 = opcode inside {rv_issue_pkg::BRANCH, rv_issue_pkg::STORE,
                                            rv_issue_pkg::ARITH};
        decoded_o.uses_rd  = !(opcode inside {rv_issue_pkg::BRANCH, rv_issue_pkg::STORE});

        // Jumps need both the branch unit and the ALU for the link value
        // Opcodes without a unit stay in the issue stage until a flush
        decoded_o.unit_needed[rv_issue_pkg::UNIT_BR] =
            opcode inside {rv_issue_pkg::BRANCH, rv_issue_pkg::JAL, rv_issue_pkg::JALR};
        decoded_o.unit_needed[rv_issue_pkg::UNIT_ALU] =
            (opcode inside {rv_issue_pkg::ARITH, rv_issue_pkg::ARITH_IMM, rv_issue_pkg::LUI,
                            rv_issue_pkg::AUIPC, rv_issue_pkg::JAL, rv_issue_pkg::JALR})
            && !mul_op;
        decoded_o.unit_needed[rv_issue_pkg::UNIT_LS] =
            opcode inside {rv_issue_pkg::LOAD, rv_issue_pkg::STORE};
        decoded_o.unit_needed[rv_issue_pkg::UNIT_MUL] = mul_op;
    end

endmodule

//--- issue_control.sv
////////////////////////////////////////////////////////////
// Issue stage control. Holds the stage valid flag and the
// registered issue packet, checks operands and unit ready,
// and produces the per-unit one-cycle issue strobe.
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "rv_issue_macros.svh"

module issue_control (
    input  logic                          clk,
    input  logic                          rst,
    input  rv_issue_pkg::decode_t         decode_i,
    input  rv_issue_pkg::decoded_t        decoded_i,
    input  rv_issue_pkg::rf_read_t        rf_i,
    input  logic [`RV_NUM_UNITS-1:0]      unit_ready_i,
    input  logic                          hold_i,
    input  logic                          flush_i,
    output logic                          advance_o,
    output logic                          decode_ready_o,
    output rv_issue_pkg::issue_packet_t   issue_pkt_o,
    output logic [`RV_NUM_UNITS-1:0]      issue_o,
    output rv_issue_pkg::mul_inputs_t     mul_o
);

    logic                     stage_valid;
    logic                     operands_ready;
    logic                     issue_valid;
    logic [`RV_NUM_UNITS-1:0] issue_ready;

    ////////////////////////////////////////////////////////////
    // Issue decision

    // Sources only block when the instruction actually reads them
    assign operands_ready = ~(rf_i.rs1_inuse & issue_pkt_o.decoded.uses_rs1)
                          & ~(rf_i.rs2_inuse & issue_pkt_o.decoded.uses_rs2);

    assign issue_valid = stage_valid & operands_ready & ~hold_i & ~flush_i;
    assign issue_ready = issue_pkt_o.decoded.unit_needed & unit_ready_i;
    assign issue_o     = {`RV_NUM_UNITS{issue_valid}} & issue_ready;

    // Stage can take a new instruction when empty or emptying now
    assign decode_ready_o = ~stage_valid | (|issue_o);
    assign advance_o      = decode_i.valid & decode_ready_o;

    ////////////////////////////////////////////////////////////
    // Issue register

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            stage_valid <= 1'b0;
        end else if (decode_ready_o) begin
            stage_valid <= decode_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance_o) begin
            issue_pkt_o.pc          <= decode_i.pc;
            issue_pkt_o.instruction <= decode_i.instruction;
            issue_pkt_o.decoded     <= decoded_i;
        end
    end

    ////////////////////////////////////////////////////////////
    // Multiply bundle

    // MUL, MULH, MULHSU, MULHU in fn3 bits 1 to 0
    assign mul_o.op  = issue_pkt_o.decoded.fn3[1:0];
    assign mul_o.rs1 = rf_i.rs1_data;
    assign mul_o.rs2 = rf_i.rs2_data;

endmodule

//--- ls_operand_gen.sv
////////////////////////////////////////////////////////////
// Load/store operand preparation. The address offset and
// the access direction are registered on advance and
// combined with the register data at issue.
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ls_operand_gen (
    input  logic                          clk,
    input  rv_issue_pkg::decode_t         decode_i,
    input  rv_issue_pkg::decoded_t        decoded_i,
    input  logic                          advance_i,
    input  rv_issue_pkg::issue_packet_t   issue_pkt_i,
    input  rv_issue_pkg::rf_read_t        rf_i,
    output rv_issue_pkg::ls_inputs_t      ls_o
);

    logic [11:0] offset_r;
    logic        load_r;
    logic        store_r;

    // Opcode bit 5 marks the split S-type immediate
    always_ff @(posedge clk) begin
        if (advance_i) begin
            offset_r <= decode_i.instruction[5] ?
                        {decode_i.instruction[31:25], decode_i.instruction[11:7]} :
                        decode_i.instruction[31:20];
            load_r   <= (decoded_i.opcode == rv_issue_pkg::LOAD);
            store_r  <= (decoded_i.opcode == rv_issue_pkg::STORE);
        end
    end

    assign ls_o.offset = offset_r;
    assign ls_o.load   = load_r;
    assign ls_o.store  = store_r;
    assign ls_o.fn3    = issue_pkt_i.decoded.fn3;
    assign ls_o.rs1    = rf_i.rs1_data;
    assign ls_o.rs2    = rf_i.rs2_data;

endmodule

//--- run_sim.sh
#!/bin/sh
# Builds and runs the decode and issue stage testbench with Verilator.
# Exits with a non-zero status unless the log holds the pass message.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -j 0 --top-module tb_decode_issue -f decode_issue.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_decode_issue > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -qx "Test passed" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

//--- rv_issue_macros.svh
////////////////////////////////////////////////////////////
// Width and count macros for the decode and issue stage.
// Included by the package and by every module that sizes
// a port or a signal from these values.
////////////////////////////////////////////////////////////

`ifndef RV_ISSUE_MACROS_SVH
`define RV_ISSUE_MACROS_SVH

// Data path width
`define RV_XLEN 32

// Execution units behind the issue stage
`define RV_NUM_UNITS 4

// Architectural register address width
`define RV_REG_AW 5

`endif

//--- rv_issue_pkg.sv
////////////////////////////////////////////////////////////
// Types shared by the decode and issue stage: opcode, unit
// and ALU operation enums, and the packed structs passed
// between decode, the issue register and the units.
////////////////////////////////////////////////////////////

`include "rv_issue_macros.svh"

package rv_issue_pkg;

    // Opcode with the two always-one low bits removed
    typedef enum logic [4:0] {
        LOAD      = 5'b00000,
        ARITH_IMM = 5'b00100,
        AUIPC     = 5'b00101,
        STORE     = 5'b01000,
        ARITH     = 5'b01100,
        LUI       = 5'b01101,
        BRANCH    = 5'b11000,
        JALR      = 5'b11001,
        JAL       = 5'b11011,
        SYSTEM    = 5'b11100
    } opcode_t;

    typedef enum logic [1:0] {
        UNIT_ALU = 2'd0,
        UNIT_BR  = 2'd1,
        UNIT_LS  = 2'd2,
        UNIT_MUL = 2'd3
    } unit_e;

    typedef enum logic [1:0] {
        ALU_CONSTANT,
        ALU_SLT,
        ALU_SHIFT,
        ALU_ADD_SUB
    } alu_op_t;

    typedef enum logic [1:0] {
        LOGIC_XOR,
        LOGIC_OR,
        LOGIC_AND,
        LOGIC_ADD
    } alu_logic_op_t;

    typedef struct packed {
        logic                valid;
        logic [31:0]         instruction;
        logic [`RV_XLEN-1:0] pc;
    } decode_t;

    typedef struct packed {
        opcode_t                  opcode;
        logic [2:0]               fn3;
        logic [`RV_REG_AW-1:0]    rs1;
        logic [`RV_REG_AW-1:0]    rs2;
        logic [`RV_REG_AW-1:0]    rd;
        logic                     uses_rs1;
        logic                     uses_rs2;
        logic                     uses_rd;
        logic [`RV_NUM_UNITS-1:0] unit_needed;
    } decoded_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0] pc;
        logic [31:0]         instruction;
        decoded_t            decoded;
    } issue_packet_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0] rs1_data;
        logic [`RV_XLEN-1:0] rs2_data;
        logic                rs1_inuse;
        logic                rs2_inuse;
    } rf_read_t;

    typedef struct packed {
        logic [`RV_XLEN:0]   in1;
        logic [`RV_XLEN:0]   in2;
        logic [`RV_XLEN-1:0] constant_adder;
        logic [4:0]          shift_amount;
        logic                lshift;
        logic                arith;
        logic                subtract;
        alu_op_t             alu_op;
        alu_logic_op_t       logic_op;
    } alu_inputs_t;

    typedef struct packed {
        logic [11:0]         offset;
        logic                load;
        logic                store;
        logic [2:0]          fn3;
        logic [`RV_XLEN-1:0] rs1;
        logic [`RV_XLEN-1:0] rs2;
    } ls_inputs_t;

    typedef struct packed {
        logic [20:0]         pc_offset;
        logic                jal;
        logic                jalr;
        logic [2:0]          fn3;
        logic [`RV_XLEN:0]   rs1;
        logic [`RV_XLEN:0]   rs2;
        logic [`RV_XLEN-1:0] issue_pc;
        logic [`RV_XLEN-1:0] pc_p4;
    } branch_inputs_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0] rs1;
        logic [`RV_XLEN-1:0] rs2;
        logic [1:0]          op;
    } mul_inputs_t;

endpackage

//--- tb_decode_issue.sv
////////////////////////////////////////////////////////////
// Testbench for the decode and issue stage. Reads one
// instruction per line from the vector file and offers it
// to the DUT, optionally stalled or flushed. The issue
// strobe and the unit's operand bundle are then checked.
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "rv_issue_macros.svh"

module tb_decode_issue;

    localparam int ISSUE_TIMEOUT = 20;

    logic                          clk;
    logic                          rst;
    rv_issue_pkg::decode_t         decode_i;
    logic                          decode_ready_o;
    rv_issue_pkg::rf_read_t        rf_i;
    logic [`RV_REG_AW-1:0]         rs1_addr_o;
    logic [`RV_REG_AW-1:0]         rs2_addr_o;
    logic [`RV_NUM_UNITS-1:0]      unit_ready_i;
    logic                          hold_i;
    logic                          flush_i;
    logic [`RV_NUM_UNITS-1:0]      issue_o;
    rv_issue_pkg::alu_inputs_t     alu_o;
    rv_issue_pkg::ls_inputs_t      ls_o;
    rv_issue_pkg::branch_inputs_t  br_o;
    rv_issue_pkg::mul_inputs_t     mul_o;

    // Current vector fields
    string       v_name;
    string       v_mode;
    logic [31:0] v_instr;
    logic [31:0] v_pc;
    logic [31:0] v_rs1;
    logic [31:0] v_rs2;
    logic [31:0] v_unit;
    logic [31:0] v_exp_a;
    logic [31:0] v_exp_b;

    string       line;
    int          fd;
    int          fields;
    int          vec_count;
    logic [31:0] seed_discard;

    decode_issue_top uut (
        .clk            (clk),
        .rst            (rst),
        .decode_i       (decode_i),
        .decode_ready_o (decode_ready_o),
        .rf_i           (rf_i),
        .rs1_addr_o     (rs1_addr_o),
        .rs2_addr_o     (rs2_addr_o),
        .unit_ready_i   (unit_ready_i),
        .hold_i         (hold_i),
        .flush_i        (flush_i),
        .issue_o        (issue_o),
        .alu_o          (alu_o),
        .ls_o           (ls_o),
        .br_o           (br_o),
        .mul_o          (mul_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_value(input string test_name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("mismatch %s expected %h actual %h", test_name, expected, actual);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    // Polls a little after each falling edge until a strobe shows up
    task automatic wait_for_issue();
        int cycles;
        cycles = 0;
        while (issue_o == '0) begin
            if (cycles >= ISSUE_TIMEOUT) begin
                $display("Timeout: %s did not issue within %0d cycles", v_name, ISSUE_TIMEOUT);
                $display("Test failed");
                $fatal(1);
            end else begin
                @(negedge clk);
                #10;
                cycles++;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Bundle checks for the unit of the vector

    task automatic check_bundle();
        if (v_unit[rv_issue_pkg::UNIT_BR]) begin
            check_value({v_name, " pc_offset"}, v_exp_a, 32'(br_o.pc_offset));
            check_value({v_name, " rs1 sign"}, v_exp_b, 32'(br_o.rs1[`RV_XLEN]));
            check_value({v_name, " issue_pc"}, v_pc, br_o.issue_pc);
            // Jumps also carry the link value
            if (v_unit[rv_issue_pkg::UNIT_ALU]) begin
                check_value({v_name, " pc_p4"}, v_pc + 32'd4, br_o.pc_p4);
            end
        end else if (v_unit[rv_issue_pkg::UNIT_LS]) begin
            check_value({v_name, " offset"}, v_exp_a, 32'(ls_o.offset));
            check_value({v_name, " direction"}, v_exp_b, 32'({ls_o.load, ls_o.store}));
        end else if (v_unit[rv_issue_pkg::UNIT_MUL]) begin
            check_value({v_name, " mul op"}, v_exp_a, 32'(mul_o.op));
            check_value({v_name, " mul rs1"}, v_exp_b, mul_o.rs1);
        end else begin
            check_value({v_name, " constant"}, v_exp_a, alu_o.constant_adder);
            check_value({v_name, " in2"}, v_exp_b, alu_o.in2[`RV_XLEN-1:0]);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // One instruction through the stage

    task automatic run_vector();
        int stall_cycles;
        int i;
        @(negedge clk);
        decode_i.valid       = 1'b1;
        decode_i.instruction = v_instr;
        decode_i.pc          = v_pc;
        rf_i.rs1_data        = v_rs1;
        rf_i.rs2_data        = v_rs2;
        rf_i.rs1_inuse       = (v_mode == "inuse");
        rf_i.rs2_inuse       = (v_mode == "inuse");
        unit_ready_i         = (v_mode == "notready") ? '0 : '1;
        #10;
        check_value({v_name, " accept"}, 32'd1, 32'(decode_ready_o));

        // Transfer taken on the rising edge puts the instruction in the issue register
        @(negedge clk);
        decode_i.valid = 1'b0;
        flush_i        = (v_mode == "flush");
        #10;
        check_value({v_name, " rs1_addr"}, 32'(v_instr[19:15]), 32'(rs1_addr_o));
        check_value({v_name, " rs2_addr"}, 32'(v_instr[24:20]), 32'(rs2_addr_o));

        if (v_mode == "flush") begin
            check_value({v_name, " flush issue"}, 32'd0, 32'(issue_o));
            @(negedge clk);
            flush_i = 1'b0;
            #10;
            check_value({v_name, " after flush issue"}, 32'd0, 32'(issue_o));
            check_value({v_name, " after flush ready"}, 32'd1, 32'(decode_ready_o));
        end else begin
            if (v_mode == "inuse" || v_mode == "notready") begin
                stall_cycles = int'($urandom % 32'd4) + 1;
                for (i = 0; i < stall_cycles; i++) begin
                    check_value({v_name, " stall issue"}, 32'd0, 32'(issue_o));
                    check_value({v_name, " stall ready"}, 32'd0, 32'(decode_ready_o));
                    @(negedge clk);
                    #10;
                end
                @(negedge clk);
                rf_i.rs1_inuse = 1'b0;
                rf_i.rs2_inuse = 1'b0;
                unit_ready_i   = '1;
                #10;
            end
            wait_for_issue();
            check_value({v_name, " unit"}, v_unit, 32'(issue_o));
            check_value({v_name, " ready at issue"}, 32'd1, 32'(decode_ready_o));
            check_bundle();
            // Strobe lasts one cycle
            @(negedge clk);
            #10;
            check_value({v_name, " strobe end"}, 32'd0, 32'(issue_o));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence

    initial begin
        seed_discard = $urandom(32'hfca1d880);
        rst          = 1'b1;
        decode_i     = '0;
        rf_i         = '0;
        unit_ready_i = '1;
        hold_i       = 1'b0;
        flush_i      = 1'b0;
        vec_count    = 0;

        repeat (8) @(negedge clk);
        rst = 1'b0;
        #10;
        check_value("reset issue", 32'd0, 32'(issue_o));
        check_value("reset ready", 32'd1, 32'(decode_ready_o));

        fd = $fopen("decode_issue_input.txt", "r");
        if (fd == 0) begin
            $display("Could not open the vector file decode_issue_input.txt");
            $display("Test failed");
            $fatal(1);
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 0 && line.substr(0, 0) != "#") begin
                    fields = $sscanf(line, "%s %h %h %h %h %s %h %h %h", v_name, v_instr,
                                     v_pc, v_rs1, v_rs2, v_mode, v_unit, v_exp_a, v_exp_b);
                    if (fields == 9) begin
                        run_vector();
                        vec_count++;
                    end else if (fields > 0) begin
                        $display("Vector line has the wrong number of columns: %s", line);
                        $display("Test failed");
                        $fatal(1);
                    end
                end
            end
            $fclose(fd);
            if (vec_count == 0) begin
                $display("No test vectors were read from the vector file");
                $display("Test failed");
                $fatal(1);
            end else begin
                $display("Test passed");
                $finish;
            end
        end
    end

endmodule
